//--- rtl/redsum_config.svh
`ifndef REDSUM_CONFIG_SVH
`define REDSUM_CONFIG_SVH

// bf16 lanes per beat, power of two.
`define RS_VECT_WIDTH   4

// width of the row-length input.
`define RS_ROW_LEN_W    8

// result credits at reset, also the maximum.
`define RS_OUT_CREDITS  2

`endif

//--- rtl/redsum_pkg.sv
package redsum_pkg;

    typedef struct packed {
        logic           sign;
        logic [7 : 0]   exp;
        logic [6 : 0]   mant;
    } bf16_t;

    typedef struct packed {
        logic           sign;
        logic [7 : 0]   exp;
        logic [22 : 0]  mant;
    } fp32_fields_t;

    // one fp32 word, as bits or as fields.
    typedef union packed {
        logic [31 : 0]  raw;
        fp32_fields_t   f;
    } fp32_u;

    typedef enum logic [1 : 0] {
        RUN,
        DRAIN,
        HOLD
    } redsum_state_e;

endpackage

//--- rtl/redsum_if.sv
`timescale 1ns/1ps

interface redsum_if;
    import redsum_pkg::*;

    logic   beat_valid;
    fp32_u  beat_sum;
    logic   beat_last;     // final beat of the row.

    modport tree (
        output  beat_valid,
        output  beat_sum,
        output  beat_last
    );

    modport acc (
        input   beat_valid,
        input   beat_sum,
        input   beat_last
    );

endinterface

//--- rtl/fp_add.sv
`timescale 1ns/1ps

module fp_add (
    input   redsum_pkg::fp32_u  a_i     ,
    input   redsum_pkg::fp32_u  b_i     ,
    output  redsum_pkg::fp32_u  sum_o
);
    import redsum_pkg::*;

    fp32_fields_t   hi,
                    lo;
    logic [23 : 0]  m_hi,
                    m_lo;
    logic [7 : 0]   exp_diff;
    logic [49 : 0]  shifted;
    logic [27 : 0]  op_hi,
                    op_lo,
                    raw_sum;
    logic [26 : 0]  norm;          // mantissa, guard, round, sticky.
    logic [4 : 0]   lz;
    logic [9 : 0]   exp_norm;
    logic [24 : 0]  m_round;
    logic           eff_sub,
                    round_up;

    // ##################################################################
    // operand order and alignment
    // ##################################################################

    always_comb begin
        if ({a_i.f.exp, a_i.f.mant} >= {b_i.f.exp, b_i.f.mant}) begin
            hi = a_i.f;
            lo = b_i.f;
        end else begin
            hi = b_i.f;
            lo = a_i.f;
        end
    end

    // zero exponent flushes the operand.
    assign m_hi     = (hi.exp == '0) ? '0 : {1'b1, hi.mant};
    assign m_lo     = (lo.exp == '0) ? '0 : {1'b1, lo.mant};
    assign eff_sub  = hi.sign ^ lo.sign;
    assign exp_diff = hi.exp - lo.exp;
    assign shifted  = {m_lo, 26'd0} >> exp_diff;

    assign op_hi    = {1'b0, m_hi, 3'b000};
    assign op_lo    = {1'b0, shifted[49 : 24], |shifted[23 : 0]};
    assign raw_sum  = eff_sub ? (op_hi - op_lo) : (op_hi + op_lo);

    // ##################################################################
    // normalize and round
    // ##################################################################

    always_comb begin
        lz = '0;
        for (int i = 0; i < 27; i++) begin
            if (raw_sum[i]) lz = 5'(26 - i);   // highest set bit wins.
        end

        if (raw_sum[27]) begin
            norm     = {raw_sum[27 : 2], raw_sum[1] | raw_sum[0]};
            exp_norm = {2'b00, hi.exp} + 10'd1;
        end else begin
            norm     = raw_sum[26 : 0] << lz;
            exp_norm = {2'b00, hi.exp} - {5'd0, lz};
        end

        // nearest even.
        round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
        m_round  = {1'b0, norm[26 : 3]} + 25'(round_up);
        if (m_round[24]) begin
            exp_norm = exp_norm + 10'd1;
        end

        if (raw_sum == '0) begin
            sum_o.raw = {hi.sign & ~eff_sub, 31'd0};    // cancellation gives +0.
        end else if (exp_norm[9] || (exp_norm == '0)) begin
            sum_o.raw = {hi.sign, 31'd0};               // underflow, flush.
        end else begin
            sum_o.f.sign = hi.sign;
            sum_o.f.exp  = exp_norm[7 : 0];
            sum_o.f.mant = m_round[24] ? m_round[23 : 1] : m_round[22 : 0];
        end
    end

endmodule

//--- rtl/fp_add_tree.sv
`timescale 1ns/1ps

`include "redsum_config.svh"

module fp_add_tree #(
    parameter int unsigned VECT_WIDTH = `RS_VECT_WIDTH
) (
    input   logic                                       clk_i       ,
    input   logic                                       reset_i     ,
    input   logic                                       in_valid_i  ,
    input   logic                                       last_i      ,
    input   redsum_pkg::bf16_t [VECT_WIDTH - 1 : 0]     vect_i      ,
    input   logic [VECT_WIDTH - 1 : 0]                  strb_i      ,
    redsum_if.tree                                      out
);
    import redsum_pkg::*;

    localparam int unsigned LEVELS      = $clog2(VECT_WIDTH);
    localparam int unsigned FIRST_LEAF  = VECT_WIDTH - 1;

    fp32_u                  leaf [VECT_WIDTH];
    logic [LEVELS - 1 : 0]  valid_q,
                            last_q;

    if ((VECT_WIDTH < 2) || ((VECT_WIDTH & (VECT_WIDTH - 1)) != 0)) begin : g_width_check
        $error("fp_add_tree: VECT_WIDTH must be a power of two, at least 2");
    end

    // bf16 is the upper half of fp32.
    always_comb begin
        for (int k = 0; k < VECT_WIDTH; k++) begin
            leaf[k].raw = strb_i[k] ? {vect_i[k], 16'h0000} : 32'h0000_0000;
        end
    end

    // heap order, node 0 is the root, children of n are 2n+1 and 2n+2.
    for (genvar n = 0; n < VECT_WIDTH - 1; n++) begin : g_node
        fp32_u  op_a,
                op_b,
                sum_d,
                sum_q;

        if (2 * n + 1 >= FIRST_LEAF) begin : g_from_leaf
            assign op_a = leaf[2 * n + 1 - FIRST_LEAF];
            assign op_b = leaf[2 * n + 2 - FIRST_LEAF];
        end else begin : g_from_node
            assign op_a = g_node[2 * n + 1].sum_q;
            assign op_b = g_node[2 * n + 2].sum_q;
        end

        fp_add i_add (
            .a_i    (   op_a    ),
            .b_i    (   op_b    ),
            .sum_o  (   sum_d   )
        );

        always_ff @(posedge clk_i) begin
            sum_q <= sum_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
            last_q  <= '0;
        end else begin
            valid_q[0] <= in_valid_i;
            last_q[0]  <= in_valid_i & last_i;
            for (int s = 1; s < LEVELS; s++) begin
                valid_q[s] <= valid_q[s - 1];
                last_q[s]  <= last_q[s - 1];
            end
        end
    end

    assign out.beat_valid = valid_q[LEVELS - 1];
    assign out.beat_sum   = g_node[0].sum_q;
    assign out.beat_last  = last_q[LEVELS - 1];

endmodule

//--- rtl/beat_counter.sv
`timescale 1ns/1ps

`include "redsum_config.svh"

module beat_counter (
    input   logic                               clk_i       ,
    input   logic                               reset_i     ,
    input   logic                               accept_i    ,
    input   logic [`RS_ROW_LEN_W - 1 : 0]       row_len_i   ,
    output  logic                               last_beat_o
);
    logic [`RS_ROW_LEN_W - 1 : 0]   count_q,
                                    len_q,
                                    row_len;

    // first beat of a row sees the live length.
    assign row_len     = (count_q == '0) ? row_len_i : len_q;
    assign last_beat_o = (count_q == row_len - 1'b1);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (accept_i) begin
            count_q <= last_beat_o ? '0 : count_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_i && (count_q == '0)) begin
            len_q <= row_len_i;
        end
    end

    a_row_len_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
        (accept_i && (count_q == '0)) |-> (row_len_i != '0));

endmodule

//--- rtl/row_accumulator.sv
`timescale 1ns/1ps

module row_accumulator (
    input   logic                   clk_i       ,
    input   logic                   reset_i     ,
    redsum_if.acc                   in          ,
    input   logic                   send_i      ,
    output  logic                   row_done_o  ,
    output  redsum_pkg::fp32_u      total_o
);
    import redsum_pkg::*;

    redsum_state_e  state_q;
    fp32_u          total_q,
                    sum;

    fp_add i_add (
        .a_i    (   total_q     ),
        .b_i    (   in.beat_sum ),
        .sum_o  (   sum         )
    );

    always_ff @(posedge clk_i) begin
        if (reset_i || send_i) begin
            state_q <= RUN;
            total_q <= '0;
        end else if (in.beat_valid) begin
            total_q <= sum;
            if (in.beat_last) state_q <= HOLD;  // total is final next cycle.
        end
    end

    assign row_done_o = (state_q == HOLD);
    assign total_o    = total_q;

    // input must be stalled until the finished total is sent.
    a_no_beat_when_done: assert property (@(posedge clk_i) disable iff (reset_i)
        in.beat_valid |-> !row_done_o);

endmodule

//--- rtl/redsum_ctrl.sv
`timescale 1ns/1ps

`include "redsum_config.svh"

module redsum_ctrl (
    input   logic   clk_i       ,
    input   logic   reset_i     ,
    input   logic   in_valid_i  ,
    input   logic   last_beat_i ,
    input   logic   row_done_i  ,
    input   logic   credit_i    ,
    output  logic   in_ready_o  ,
    output  logic   accept_o    ,
    output  logic   send_o
);
    import redsum_pkg::*;

    localparam int unsigned CNT_W = $clog2(`RS_OUT_CREDITS + 1);

    redsum_state_e          state_q,
                            state_d;
    logic [CNT_W - 1 : 0]   credit_q;
    logic                   has_credit;

    assign has_credit = (credit_q != '0);
    assign in_ready_o = (state_q == RUN);
    assign accept_o   = in_valid_i & in_ready_o;
    assign send_o     = (state_q == HOLD) & has_credit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RUN:     if (accept_o && last_beat_i) state_d = DRAIN;
            DRAIN:   if (row_done_i) state_d = HOLD;    // tree and adder emptied.
            HOLD:    if (has_credit) state_d = RUN;
            default: state_d = RUN;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q  <= RUN;
            credit_q <= CNT_W'(`RS_OUT_CREDITS);
        end else begin
            state_q <= state_d;
            case ({credit_i, send_o})
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: ;
            endcase
        end
    end

    a_credit_max: assert property (@(posedge clk_i) disable iff (reset_i)
        credit_q <= CNT_W'(`RS_OUT_CREDITS));

    a_no_extra_credit: assert property (@(posedge clk_i) disable iff (reset_i)
        credit_i |-> (credit_q != CNT_W'(`RS_OUT_CREDITS)));

endmodule

//--- rtl/redsum_top.sv
`timescale 1ns/1ps

`include "redsum_config.svh"

module redsum_top (
    input   logic                                           clk_i       ,
    input   logic                                           reset_i     ,
    input   logic                                           in_valid_i  ,
    output  logic                                           in_ready_o  ,
    input   redsum_pkg::bf16_t [`RS_VECT_WIDTH - 1 : 0]     in_vect_i   ,
    input   logic [`RS_VECT_WIDTH - 1 : 0]                  in_strb_i   ,
    input   logic [`RS_ROW_LEN_W - 1 : 0]                   row_len_i   ,
    output  logic                                           res_valid_o ,
    output  redsum_pkg::fp32_u                              res_o       ,
    input   logic                                           credit_i
);
    logic   accept,
            last_beat,
            row_done,
            send;

    redsum_if rs_if ();

    redsum_ctrl i_ctrl (
        .clk_i          (   clk_i       ),
        .reset_i        (   reset_i     ),
        .in_valid_i     (   in_valid_i  ),
        .last_beat_i    (   last_beat   ),
        .row_done_i     (   row_done    ),
        .credit_i       (   credit_i    ),
        .in_ready_o     (   in_ready_o  ),
        .accept_o       (   accept      ),
        .send_o         (   send        )
    );

    beat_counter i_count (
        .clk_i          (   clk_i       ),
        .reset_i        (   reset_i     ),
        .accept_i       (   accept      ),
        .row_len_i      (   row_len_i   ),
        .last_beat_o    (   last_beat   )
    );

    fp_add_tree #(
        .VECT_WIDTH     (   `RS_VECT_WIDTH  )
    ) i_tree (
        .clk_i          (   clk_i       ),
        .reset_i        (   reset_i     ),
        .in_valid_i     (   accept      ),
        .last_i         (   last_beat   ),
        .vect_i         (   in_vect_i   ),
        .strb_i         (   in_strb_i   ),
        .out            (   rs_if.tree  )
    );

    row_accumulator i_acc (
        .clk_i          (   clk_i       ),
        .reset_i        (   reset_i     ),
        .in             (   rs_if.acc   ),
        .send_i         (   send        ),
        .row_done_o     (   row_done    ),
        .total_o        (   res_o       )
    );

    assign res_valid_o = send;     // one pulse per row.

endmodule

//--- sim/redsum_tb.sv
`timescale 1ns/1ps

`include "redsum_config.svh"

module redsum_tb;
    import redsum_pkg::*;

    localparam int  LANES   = `RS_VECT_WIDTH;
    localparam int  N_ROWS  = 12;
    localparam int  N_FREE  = 8;       // rows before credits are withheld.
    localparam int  PERIOD  = 8;

    logic                           clk;
    logic                           reset;
    logic                           in_valid;
    logic                           in_ready;
    bf16_t [LANES - 1 : 0]          in_vect;
    logic [LANES - 1 : 0]           in_strb;
    logic [`RS_ROW_LEN_W - 1 : 0]   row_len;
    logic                           res_valid;
    fp32_u                          res_o;
    logic                           credit;

    // beat k of a row carries the table lane value times (k + 1).
    int                     tbl_len  [N_ROWS];
    shortreal               tbl_lane [N_ROWS][LANES];
    logic [LANES - 1 : 0]   tbl_mask [N_ROWS];
    bit                     tbl_rnd  [N_ROWS];

    logic [31 : 0]  exp_q [$];
    int             rx_count        = 0;
    int             pending_credits = 0;
    bit             credits_held    = 1'b0;

    redsum_top dut (
        .clk_i          (   clk         ),
        .reset_i        (   reset       ),
        .in_valid_i     (   in_valid    ),
        .in_ready_o     (   in_ready    ),
        .in_vect_i      (   in_vect     ),
        .in_strb_i      (   in_strb     ),
        .row_len_i      (   row_len     ),
        .res_valid_o    (   res_valid   ),
        .res_o          (   res_o       ),
        .credit_i       (   credit      )
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ##################################################################
    // helpers
    // ##################################################################

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic compare(input string name, input logic [31 : 0] got,
                           input logic [31 : 0] exp);
        string msg;
        if (got !== exp) begin
            msg = $sformatf("error %s got 0x%08h expected 0x%08h", name, got, exp);
            fail_run(msg);
        end
    endtask

    task automatic set_row(input int idx, input int len, input shortreal a,
                           input shortreal b, input shortreal c, input shortreal d,
                           input logic [LANES - 1 : 0] mask, input bit rnd);
        tbl_len[idx]     = len;
        tbl_lane[idx][0] = a;
        tbl_lane[idx][1] = b;
        tbl_lane[idx][2] = c;
        tbl_lane[idx][3] = d;
        tbl_mask[idx]    = mask;
        tbl_rnd[idx]     = rnd;
    endtask

    // bf16 keeps the upper half of the fp32 pattern.
    function automatic logic [15 : 0] to_bf16(input shortreal v);
        logic [31 : 0] bits;
        bits = $shortrealtobits(v);
        return bits[31 : 16];
    endfunction

    function automatic shortreal from_bf16(input logic [15 : 0] b);
        return $bitstoshortreal({b, 16'h0000});
    endfunction

    task automatic drive_row(input int r);
        shortreal               sum;
        logic [LANES - 1 : 0]   mask;
        logic [15 : 0]          lane;
        bit                     ready;
        sum = 0.0;
        for (int k = 0; k < tbl_len[r]; k++) begin
            mask = tbl_rnd[r] ? $urandom_range(0, (1 << LANES) - 1) : tbl_mask[r];
            for (int j = 0; j < LANES; j++) begin
                lane       = to_bf16(tbl_lane[r][j] * (k + 1));
                in_vect[j] = lane;
                if (mask[j]) sum = sum + from_bf16(lane);
            end
            in_strb  = mask;
            row_len  = `RS_ROW_LEN_W'(tbl_len[r]);
            in_valid = 1'b1;
            do begin
                @(negedge clk);
                ready = in_ready;   // stable until the next edge.
                @(posedge clk);
            end while (!ready);
            #1;
        end
        in_valid = 1'b0;
        exp_q.push_back((sum == 0.0) ? 32'h0000_0000 : $shortrealtobits(sum));
    endtask

    // ##################################################################
    // sink and credit return
    // ##################################################################

    initial begin
        forever begin
            @(negedge clk);
            if (res_valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("a result arrived with no row pending");
                end else begin
                    compare("res_o", res_o.raw, exp_q.pop_front());
                    rx_count++;
                    pending_credits++;
                end
            end
        end
    end

    initial begin
        forever begin
            wait ((pending_credits > 0) && !credits_held);
            repeat ($urandom_range(0, 6)) @(posedge clk);
            @(posedge clk);
            #1 credit = 1'b1;
            @(posedge clk);
            #1 credit = 1'b0;
            pending_credits--;
        end
    end

    initial begin
        longint limit;
        int     beats;
        void'($urandom(87286));
        reset    = 1'b1;
        in_valid = 1'b0;
        in_vect  = '0;
        in_strb  = '0;
        row_len  = '0;
        credit   = 1'b0;

        set_row(0,  1,  1.0,    2.0,    3.0,    4.0,    4'b1111, 1'b0);
        set_row(1,  3,  0.5,    -1.5,   2.0,    6.0,    4'b1111, 1'b0);
        set_row(2,  2,  3.0,    5000.0, -2.0,   9000.0, 4'b0101, 1'b0);
        set_row(3,  4,  7.0,    6000.0, -3.0,   2.5,    4'b0000, 1'b0);  // all masked.
        set_row(4,  17, 1.0,    2.0,    -0.5,   3.0,    4'b1111, 1'b0);
        set_row(5,  5,  2.0,    -2.0,   3.5,    -3.5,   4'b1111, 1'b0);  // cancels.
        set_row(6,  6,  1.5,    4.0,    -1.0,   7.0,    4'b0000, 1'b1);
        set_row(7,  1,  5.0,    0.5,    0.0,    -7.0,   4'b1010, 1'b0);
        set_row(8,  2,  1.0,    1.0,    1.0,    1.0,    4'b1111, 1'b0);
        set_row(9,  1,  2.0,    -0.5,   4.0,    1.0,    4'b1111, 1'b0);
        set_row(10, 3,  0.5,    1.0,    1.5,    2.0,    4'b0000, 1'b1);
        set_row(11, 1,  -3.0,   6.0,    0.5,    2.0,    4'b1111, 1'b0);

        beats = 0;
        for (int r = 0; r < N_ROWS; r++) beats += tbl_len[r];
        limit = 2 * (beats + 40 * N_ROWS);
        fork
            begin
                #(limit * PERIOD);
                fail_run("timeout, not all results arrived in time");
            end
        join_none

        repeat (16) @(posedge clk);
        #1 reset = 1'b0;

        repeat (4) begin
            @(negedge clk);
            compare("res_valid_o", res_valid, 1'b0);
            compare("in_ready_o", in_ready, 1'b1);
        end
        @(posedge clk);
        #1;

        for (int r = 0; r < N_FREE; r++) drive_row(r);
        wait ((rx_count == N_FREE) && (pending_credits == 0));

        // starve the sender of credits.
        credits_held = 1'b1;
        fork
            begin
                for (int r = N_FREE; r < N_ROWS; r++) drive_row(r);
            end
        join_none
        repeat (80) @(posedge clk);
        compare("results while credits held", rx_count - N_FREE, `RS_OUT_CREDITS);
        credits_held = 1'b0;

        wait (rx_count == N_ROWS);
        repeat (20) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+rtl
rtl/redsum_pkg.sv
rtl/redsum_if.sv
rtl/fp_add.sv
rtl/fp_add_tree.sv
rtl/beat_counter.sv
rtl/row_accumulator.sv
rtl/redsum_ctrl.sv
rtl/redsum_top.sv
sim/redsum_tb.sv
